// ==== cpuCfg_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and address width
`define CPU_XLEN 32

// architectural register count, register 0 reads as zero
`define CPU_REGS 32

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// words of data memory reachable by the test program
`define CPU_DMEM_WORDS 64

`endif

// ==== cpuPkg.sv ====
package cpuPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        RType = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDI  = 6'h08,
        LW    = 6'h23,
        SW    = 6'h2b
    } opcodeT;

    // funct field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        SLL = 6'h00,
        JR  = 6'h08,
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } functT;

    // class of alu operation chosen by the main decoder
    typedef enum logic [1:0] {
        AluOpAdd   = 2'b00,
        AluOpSub   = 2'b01,
        AluOpFunct = 2'b10
    } aluOpT;

    // concrete alu function
    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4,
        AluSll = 3'd5
    } aluFnT;

endpackage

// ==== opcodeControl.sv ====
`timescale 1ns/10ps

module opcodeControl (
    input  cpuPkg::opcodeT opcode,
    input  cpuPkg::functT  funct,
    output logic           regDst,
    output logic           jump,
    output logic           jumpAndLink,
    output logic           jumpRegister,
    output logic           branch,
    output logic           branchNe,
    output logic           memRead,
    output logic           memToReg,
    output cpuPkg::aluOpT  aluOp,
    output logic           memWrite,
    output logic           aluSrc,
    output logic           regWrite,
    output logic           shiftLeftLogical
);

    logic isR;
    logic isJ;
    logic isJal;
    logic isBeq;
    logic isBne;
    logic isAddi;
    logic isLw;
    logic isSw;
    logic isJr;
    logic isSll;

    // one-hot instruction class from opcode
    always_comb begin
        isR    = (opcode == cpuPkg::RType);
        isJ    = (opcode == cpuPkg::J);
        isJal  = (opcode == cpuPkg::JAL);
        isBeq  = (opcode == cpuPkg::BEQ);
        isBne  = (opcode == cpuPkg::BNE);
        isAddi = (opcode == cpuPkg::ADDI);
        isLw   = (opcode == cpuPkg::LW);
        isSw   = (opcode == cpuPkg::SW);
    end

    // funct only means something for R-type
    assign isJr  = isR && (funct == cpuPkg::JR);
    assign isSll = isR && (funct == cpuPkg::SLL);

    assign regDst           = isR;
    assign jump             = isJ || isJal;
    assign jumpAndLink      = isJal;
    assign jumpRegister     = isJr;
    assign branch           = isBeq;
    assign branchNe         = isBne;
    assign memRead          = isLw;
    assign memToReg         = isLw;
    assign memWrite         = isSw;
    assign aluSrc           = isLw || isSw || isAddi;
    assign shiftLeftLogical = isSll;

    // listed positively so an unknown opcode writes nothing
    assign regWrite = (isR && !isJr) || isAddi || isLw || isJal;

    always_comb begin
        if (isR) begin
            aluOp = cpuPkg::AluOpFunct;
        end else if (isBeq || isBne) begin
            aluOp = cpuPkg::AluOpSub;
        end else begin
            // address and addi, also the harmless default
            aluOp = cpuPkg::AluOpAdd;
        end
    end

endmodule

// ==== aluControl.sv ====
`timescale 1ns/10ps

module aluControl (
    input  cpuPkg::aluOpT aluOp,
    input  cpuPkg::functT funct,
    output cpuPkg::aluFnT aluFn
);

    logic [2:0] fnCode;

    always_comb begin
        case (aluOp)
            cpuPkg::AluOpAdd: fnCode = cpuPkg::AluAdd;
            // beq and bne compare through the zero flag
            cpuPkg::AluOpSub: fnCode = cpuPkg::AluSub;
            cpuPkg::AluOpFunct: begin
                case (funct)
                    cpuPkg::ADD: fnCode = cpuPkg::AluAdd;
                    cpuPkg::SUB: fnCode = cpuPkg::AluSub;
                    cpuPkg::AND: fnCode = cpuPkg::AluAnd;
                    cpuPkg::OR:  fnCode = cpuPkg::AluOr;
                    cpuPkg::SLT: fnCode = cpuPkg::AluSlt;
                    cpuPkg::SLL: fnCode = cpuPkg::AluSll;
                    // jr and anything unknown
                    default:     fnCode = cpuPkg::AluAdd;
                endcase
            end
            default: fnCode = cpuPkg::AluAdd;
        endcase
    end

    assign aluFn = cpuPkg::aluFnT'(fnCode);

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps
`include "cpuCfg_cfg.svh"

module alu (
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  logic [4:0]           shamt,
    input  cpuPkg::aluFnT        aluFn,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 zero
);

    logic lessThan;

    // signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluFn)
            cpuPkg::AluAdd: result = a + b;
            cpuPkg::AluSub: result = a - b;
            cpuPkg::AluAnd: result = a & b;
            cpuPkg::AluOr:  result = a | b;
            cpuPkg::AluSlt: result = {{(`CPU_XLEN-1){1'b0}}, lessThan};
            // sll moves rt, the a operand is not involved
            cpuPkg::AluSll: result = b << shamt;
            default:        result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== registerFile.sv ====
`timescale 1ns/10ps
`include "cpuCfg_cfg.svh"

module registerFile #(
    parameter int AddrW = $clog2(`CPU_REGS)
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [AddrW-1:0]     raddr1,
    input  logic [AddrW-1:0]     raddr2,
    input  logic [AddrW-1:0]     waddr,
    input  logic                 we,
    input  logic [`CPU_XLEN-1:0] wdata,
    output logic [`CPU_XLEN-1:0] rdata1,
    output logic [`CPU_XLEN-1:0] rdata2
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // register 0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== singleCycleCpu.sv ====
`timescale 1ns/10ps
`include "cpuCfg_cfg.svh"

module singleCycleCpu (
    input  logic                 clk,
    input  logic                 arstN,
    output logic [`CPU_XLEN-1:0] pc,
    input  logic [31:0]          instr,
    output logic [`CPU_XLEN-1:0] dmemAddr,
    output logic [`CPU_XLEN-1:0] dmemWdata,
    output logic                 dmemWe,
    output logic                 dmemRe,
    input  logic [`CPU_XLEN-1:0] dmemRdata
);

    localparam int AddrW = $clog2(`CPU_REGS);
    localparam logic [AddrW-1:0] LinkReg = AddrW'(31);

    // instruction fields
    cpuPkg::opcodeT   opcode;
    cpuPkg::functT    funct;
    logic [AddrW-1:0] rs;
    logic [AddrW-1:0] rt;
    logic [AddrW-1:0] rd;
    logic [4:0]       shamt;
    logic [15:0]      imm16;
    logic [25:0]      jumpIndex;

    // control levels
    logic          regDst;
    logic          jump;
    logic          jumpAndLink;
    logic          jumpRegister;
    logic          branch;
    logic          branchNe;
    logic          memRead;
    logic          memToReg;
    logic          memWrite;
    logic          aluSrc;
    logic          regWrite;
    logic          shiftLeftLogical;
    cpuPkg::aluOpT aluOp;
    cpuPkg::aluFnT aluFn;

    // datapath
    logic [`CPU_XLEN-1:0] rdata1;
    logic [`CPU_XLEN-1:0] rdata2;
    logic [`CPU_XLEN-1:0] immExt;
    logic [`CPU_XLEN-1:0] aluB;
    logic [4:0]           aluShamt;
    logic [`CPU_XLEN-1:0] aluResult;
    logic                 aluZero;
    logic [AddrW-1:0]     waddr;
    logic [`CPU_XLEN-1:0] wdata;
    logic [`CPU_XLEN-1:0] pcPlus4;
    logic [`CPU_XLEN-1:0] branchTarget;
    logic [`CPU_XLEN-1:0] jumpTarget;
    logic [`CPU_XLEN-1:0] nextPc;
    logic                 branchTaken;

    assign opcode    = cpuPkg::opcodeT'(instr[31:26]);
    assign funct     = cpuPkg::functT'(instr[5:0]);
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign rd        = instr[15:11];
    assign shamt     = instr[10:6];
    assign imm16     = instr[15:0];
    assign jumpIndex = instr[25:0];

    opcodeControl uOpcodeControl (
        .opcode           (opcode),
        .funct            (funct),
        .regDst           (regDst),
        .jump             (jump),
        .jumpAndLink      (jumpAndLink),
        .jumpRegister     (jumpRegister),
        .branch           (branch),
        .branchNe         (branchNe),
        .memRead          (memRead),
        .memToReg         (memToReg),
        .aluOp            (aluOp),
        .memWrite         (memWrite),
        .aluSrc           (aluSrc),
        .regWrite         (regWrite),
        .shiftLeftLogical (shiftLeftLogical)
    );

    aluControl uAluControl (
        .aluOp (aluOp),
        .funct (funct),
        .aluFn (aluFn)
    );

    registerFile uRegisterFile (
        .clk    (clk),
        .arstN  (arstN),
        .raddr1 (rs),
        .raddr2 (rt),
        .waddr  (waddr),
        .we     (regWrite),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // sign extension for addi, lw, sw and branch offsets
    assign immExt = {{(`CPU_XLEN-16){imm16[15]}}, imm16};
    assign aluB   = aluSrc ? immExt : rdata2;
    // shamt only reaches the alu for sll
    assign aluShamt = shiftLeftLogical ? shamt : 5'd0;

    alu uAlu (
        .a      (rdata1),
        .b      (aluB),
        .shamt  (aluShamt),
        .aluFn  (aluFn),
        .result (aluResult),
        .zero   (aluZero)
    );

    // write-back: jal links into r31
    assign waddr = jumpAndLink ? LinkReg : (regDst ? rd : rt);
    assign wdata = jumpAndLink ? pcPlus4 : (memToReg ? dmemRdata : aluResult);

    assign dmemAddr  = aluResult;
    assign dmemWdata = rdata2;
    assign dmemWe    = memWrite;
    assign dmemRe    = memRead;

    // next pc, no delay slot
    assign pcPlus4      = pc + `CPU_XLEN'(4);
    assign branchTarget = pcPlus4 + {immExt[`CPU_XLEN-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[`CPU_XLEN-1:28], jumpIndex, 2'b00};
    assign branchTaken  = (branch && aluZero) || (branchNe && !aluZero);

    always_comb begin
        if (jumpRegister) begin
            nextPc = rdata1;
        end else if (jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `CPU_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== cpuChecker.sv ====
`timescale 1ns/10ps
`include "cpuCfg_cfg.svh"

module cpuChecker (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic [31:0]          instr,
    input  logic [`CPU_XLEN-1:0] dmemAddr,
    input  logic [`CPU_XLEN-1:0] dmemWdata,
    input  logic                 dmemWe,
    input  logic                 dmemRe,
    output int                   checkCount,
    output int                   errorCount
);

    localparam int DmemIdxW = $clog2(`CPU_DMEM_WORDS);

    logic [`CPU_XLEN-1:0] modelPc;
    logic [`CPU_XLEN-1:0] modelRegs [`CPU_REGS];
    logic [`CPU_XLEN-1:0] modelMem [`CPU_DMEM_WORDS];
    int checks = 0;
    int errors = 0;

    assign checkCount = checks;
    assign errorCount = errors;

    // same pattern the testbench loads into data memory
    function automatic logic [31:0] fillWord(int idx);
        return 32'hC0DE_0000 ^ (32'(idx) * 32'h9E37_79B9);
    endfunction

    task automatic expectValue(input string field, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL at %0t ns: %s is %h, model expects %h", $time, field, got, want);
        end
    endtask

    task automatic writeReg(input logic [4:0] idx, input logic [31:0] value);
        if (idx != 5'd0) begin
            modelRegs[idx] = value;
        end
    endtask

    task automatic resetModel();
        modelPc = `CPU_RESET_PC;
        for (int i = 0; i < `CPU_REGS; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
            modelMem[i] = fillWord(i);
        end
    endtask

    // one instruction of the reference ISA, compared before it retires
    task automatic stepModel();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immExt;
        logic [31:0] addr;
        logic [31:0] pcPlus4;
        logic [31:0] nextPc;
        logic        expWe;
        logic        expRe;
        a       = modelRegs[instr[25:21]];
        b       = modelRegs[instr[20:16]];
        immExt  = {{16{instr[15]}}, instr[15:0]};
        addr    = a + immExt;
        pcPlus4 = modelPc + 32'd4;
        nextPc  = pcPlus4;
        expWe   = 1'b0;
        expRe   = 1'b0;
        expectValue("pc", pc, modelPc);
        case (instr[31:26])
            cpuPkg::RType: begin
                case (instr[5:0])
                    cpuPkg::ADD: writeReg(instr[15:11], a + b);
                    cpuPkg::SUB: writeReg(instr[15:11], a - b);
                    cpuPkg::AND: writeReg(instr[15:11], a & b);
                    cpuPkg::OR:  writeReg(instr[15:11], a | b);
                    cpuPkg::SLT: writeReg(instr[15:11], {31'd0, $signed(a) < $signed(b)});
                    cpuPkg::SLL: writeReg(instr[15:11], b << instr[10:6]);
                    cpuPkg::JR:  nextPc = a;
                    default: ;
                endcase
            end
            cpuPkg::ADDI: writeReg(instr[20:16], addr);
            cpuPkg::LW: begin
                expRe = 1'b1;
                expectValue("dmemAddr", dmemAddr, addr);
                writeReg(instr[20:16], modelMem[addr[DmemIdxW+1:2]]);
            end
            cpuPkg::SW: begin
                expWe = 1'b1;
                expectValue("dmemAddr", dmemAddr, addr);
                expectValue("dmemWdata", dmemWdata, b);
                modelMem[addr[DmemIdxW+1:2]] = b;
            end
            cpuPkg::BEQ: if (a == b) nextPc = pcPlus4 + {immExt[29:0], 2'b00};
            cpuPkg::BNE: if (a != b) nextPc = pcPlus4 + {immExt[29:0], 2'b00};
            cpuPkg::J:   nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
            cpuPkg::JAL: begin
                writeReg(5'd31, pcPlus4);
                nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
            end
            default: ;
        endcase
        expectValue("dmemWe", 32'(dmemWe), 32'(expWe));
        expectValue("dmemRe", 32'(dmemRe), 32'(expRe));
        modelPc = nextPc;
    endtask

    // mid-cycle sampling, all DUT outputs have settled
    always @(negedge clk) begin
        if (!arstN) begin
            resetModel();
            expectValue("pc in reset", pc, `CPU_RESET_PC);
            expectValue("dmemWe in reset", 32'(dmemWe), 32'd0);
            expectValue("dmemRe in reset", 32'(dmemRe), 32'd0);
        end else begin
            stepModel();
        end
    end

endmodule

// ==== tbCpu.sv ====
`timescale 1ns/10ps
`include "cpuCfg_cfg.svh"

module tbCpu;

    localparam int ImemWords     = 256;
    localparam int DmemIdxW      = $clog2(`CPU_DMEM_WORDS);
    localparam int TimeoutCycles = 2000;

    logic                 clk = 1'b0;
    logic                 arstN = 1'b0;
    logic [`CPU_XLEN-1:0] pc;
    logic [31:0]          instr;
    logic [`CPU_XLEN-1:0] dmemAddr;
    logic [`CPU_XLEN-1:0] dmemWdata;
    logic [`CPU_XLEN-1:0] dmemRdata;
    logic                 dmemWe;
    logic                 dmemRe;
    int                   checkCount;
    int                   errorCount;

    logic [31:0]          instrMem [ImemWords];
    logic [`CPU_XLEN-1:0] dataMem [`CPU_DMEM_WORDS];
    logic [31:0]          endPc;
    int                   slot;

    always #10 clk = ~clk;

    singleCycleCpu DUT (
        .clk       (clk),
        .arstN     (arstN),
        .pc        (pc),
        .instr     (instr),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemWe    (dmemWe),
        .dmemRe    (dmemRe),
        .dmemRdata (dmemRdata)
    );

    cpuChecker uCpuChecker (
        .clk        (clk),
        .arstN      (arstN),
        .pc         (pc),
        .instr      (instr),
        .dmemAddr   (dmemAddr),
        .dmemWdata  (dmemWdata),
        .dmemWe     (dmemWe),
        .dmemRe     (dmemRe),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    // both memories answer in the same cycle
    assign instr     = instrMem[pc[9:2]];
    assign dmemRdata = dataMem[dmemAddr[DmemIdxW+1:2]];

    function automatic logic [31:0] fillWord(int idx);
        return 32'hC0DE_0000 ^ (32'(idx) * 32'h9E37_79B9);
    endfunction

    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
                dataMem[i] <= fillWord(i);
            end
        end else if (dmemWe) begin
            dataMem[dmemAddr[DmemIdxW+1:2]] <= dmemWdata;
        end
    end

    function automatic logic [4:0] pickReg();
        return 5'(1 + ($urandom % 15));
    endfunction

    function automatic logic [31:0] encodeR(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                            logic [4:0] rd, logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(logic [5:0] op, int targetWord);
        return {op, 26'(targetWord)};
    endfunction

    task automatic emitWord(input logic [31:0] word);
        instrMem[slot] = word;
        slot++;
    endtask

    task automatic emitAluOp();
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        rs = pickReg();
        rt = pickReg();
        rd = pickReg();
        case ($urandom % 7)
            0: emitWord(encodeR(cpuPkg::ADD, rs, rt, rd, 5'd0));
            1: emitWord(encodeR(cpuPkg::SUB, rs, rt, rd, 5'd0));
            2: emitWord(encodeR(cpuPkg::AND, rs, rt, rd, 5'd0));
            3: emitWord(encodeR(cpuPkg::OR, rs, rt, rd, 5'd0));
            4: emitWord(encodeR(cpuPkg::SLT, rs, rt, rd, 5'd0));
            5: emitWord(encodeR(cpuPkg::SLL, 5'd0, rt, rd, 5'($urandom % 32)));
            default: emitWord(encodeI(cpuPkg::ADDI, rs, rt, 16'($urandom)));
        endcase
    endtask

    task automatic emitStore();
        logic [4:0] base;
        int word;
        int part;
        base = pickReg();
        word = $urandom % `CPU_DMEM_WORDS;
        part = $urandom % (word + 1);
        if ($urandom % 4 == 0) begin
            // r0 is written first and must still act as a zero base
            emitWord(encodeI(cpuPkg::ADDI, pickReg(), 5'd0, 16'($urandom)));
            emitWord(encodeI(cpuPkg::SW, 5'd0, pickReg(), 16'(word * 4)));
        end else begin
            emitWord(encodeI(cpuPkg::ADDI, 5'd0, base, 16'((word - part) * 4)));
            emitWord(encodeI(cpuPkg::SW, base, pickReg(), 16'(part * 4)));
        end
    endtask

    task automatic emitLoad();
        logic [4:0] base;
        logic [4:0] dst;
        int word;
        int part;
        base = pickReg();
        dst  = pickReg();
        word = $urandom % `CPU_DMEM_WORDS;
        part = $urandom % (word + 1);
        emitWord(encodeI(cpuPkg::ADDI, 5'd0, base, 16'((word - part) * 4)));
        emitWord(encodeI(cpuPkg::LW, base, dst, 16'(part * 4)));
        // loaded value becomes visible at this store
        emitWord(encodeI(cpuPkg::SW, 5'd0, dst, 16'(($urandom % `CPU_DMEM_WORDS) * 4)));
    endtask

    task automatic emitBranch();
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        int skip;
        op   = ($urandom % 2 == 0) ? cpuPkg::BEQ : cpuPkg::BNE;
        rs   = ($urandom % 4 == 0) ? 5'd0 : pickReg();
        rt   = ($urandom % 2 == 0) ? rs : pickReg();
        skip = 1 + $urandom % 3;
        emitWord(encodeI(op, rs, rt, 16'(skip)));
        repeat (skip) emitAluOp();
    endtask

    // jal into a short routine that returns with jr r31
    task automatic emitCall();
        int start;
        start = slot;
        emitWord(encodeJ(cpuPkg::JAL, start + 2));
        emitWord(encodeJ(cpuPkg::J, start + 5));
        emitAluOp();
        emitAluOp();
        emitWord(encodeR(cpuPkg::JR, 5'd31, 5'd0, 5'd0, 5'd0));
    endtask

    task automatic emitJumpRegister();
        logic [4:0] target;
        int start;
        target = pickReg();
        start  = slot;
        emitWord(encodeI(cpuPkg::ADDI, 5'd0, target, 16'((start + 3) * 4)));
        emitWord(encodeR(cpuPkg::JR, target, 5'd0, 5'd0, 5'd0));
        emitAluOp();
    endtask

    task automatic buildProgram();
        int endWord;
        slot = 0;
        // seed all working registers with addi from the reset PC on
        for (int r = 1; r < 16; r++) begin
            emitWord(encodeI(cpuPkg::ADDI, 5'd0, 5'(r), 16'($urandom)));
        end
        while (slot < ImemWords - 8) begin
            case ($urandom % 10)
                4: emitStore();
                5: emitLoad();
                6, 7: emitBranch();
                8: emitCall();
                9: emitJumpRegister();
                default: emitAluOp();
            endcase
        end
        endWord = slot;
        endPc   = 32'(endWord * 4);
        while (slot < ImemWords) begin
            emitWord(encodeJ(cpuPkg::J, endWord));
        end
    endtask

    initial begin
        int cycles;
        bit timedOut;
        void'($urandom(66));
        buildProgram();
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        cycles = 0;
        while (pc !== endPc && cycles < TimeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        timedOut = (pc !== endPc);
        if (timedOut) begin
            $display("ERROR: program never reached its end within %0d cycles", TimeoutCycles);
        end else begin
            // a few more cycles on the self-jump
            repeat (4) @(negedge clk);
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (!timedOut && errorCount == 0 && checkCount > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
cpuPkg.sv
opcodeControl.sv
aluControl.sv
alu.sv
registerFile.sv
singleCycleCpu.sv
cpuChecker.sv
tbCpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f sources.f --top-module tbCpu -o simCpu
./obj_dir/simCpu > sim.log
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
